//--- design/cache_bank_pkg.sv
`default_nettype none

package cache_bank_pkg;

    localparam int WORD_W         = 32;
    localparam int WORDS_PER_LINE = 4;
    localparam int OFFSET_W       = $clog2(WORDS_PER_LINE);
    localparam int LINE_W         = WORD_W * WORDS_PER_LINE;
    localparam int INDEX_W        = 4;
    localparam int NUM_LINES      = 1 << INDEX_W;
    localparam int TAG_W          = 4;
    localparam int LINE_ADDR_W    = TAG_W + INDEX_W;
    localparam int MSHR_SIZE      = 8;
    localparam int MSHR_ID_W      = $clog2(MSHR_SIZE);
    localparam int CORE_TAG_W     = 4;

    typedef struct packed {
        logic [TAG_W-1:0]   tag;
        logic [INDEX_W-1:0] index;
    } line_addr_t;

    typedef struct packed {
        line_addr_t          line;
        logic [OFFSET_W-1:0] offset;
    } word_addr_t;

    typedef struct packed {
        logic [CORE_TAG_W-1:0] core_tag;
        word_addr_t            addr;
    } core_req_t;

    typedef struct packed {
        logic [CORE_TAG_W-1:0] core_tag;
        logic [WORD_W-1:0]     data;
    } core_rsp_t;

    // what a miss entry must remember to answer the core
    typedef struct packed {
        logic [CORE_TAG_W-1:0] core_tag;
        logic [OFFSET_W-1:0]   offset;
    } mshr_data_t;

    typedef struct packed {
        logic [MSHR_ID_W-1:0] id;
        line_addr_t           addr;
    } mem_req_t;

    typedef struct packed {
        logic [MSHR_ID_W-1:0] id;
        logic [LINE_W-1:0]    line;
    } mem_rsp_t;

    typedef enum logic [2:0] {
        IDLE,
        TAG_CHECK,
        MEM_ISSUE,
        FILL,
        REPLAY
    } bank_state_e;

endpackage

`default_nettype wire

//--- design/miss_resrv.sv
`timescale 1ns/10ps
`default_nettype none

module miss_resrv (
    input  wire                                      clk,
    input  wire                                      reset,
    input  wire                                      alloc_valid_i,
    input  wire cache_bank_pkg::line_addr_t          alloc_addr_i,
    input  wire cache_bank_pkg::mshr_data_t          alloc_data_i,
    output logic [cache_bank_pkg::MSHR_ID_W-1:0]     alloc_id_o,
    output logic                                     alloc_ready_o,
    input  wire                                      fill_valid_i,
    input  wire [cache_bank_pkg::MSHR_ID_W-1:0]      fill_id_i,
    output cache_bank_pkg::line_addr_t               fill_addr_o,
    input  wire cache_bank_pkg::line_addr_t          lookup_addr_i,
    input  wire [cache_bank_pkg::MSHR_ID_W-1:0]      lookup_id_i,
    input  wire                                      lookup_replay_i,
    output logic                                     lookup_match_o,
    output logic                                     dequeue_valid_o,
    output logic [cache_bank_pkg::MSHR_ID_W-1:0]     dequeue_id_o,
    output cache_bank_pkg::line_addr_t               dequeue_addr_o,
    output cache_bank_pkg::mshr_data_t               dequeue_data_o,
    input  wire                                      dequeue_ready_i,
    input  wire                                      release_valid_i,
    input  wire [cache_bank_pkg::MSHR_ID_W-1:0]      release_id_i
);
    import cache_bank_pkg::*;

    line_addr_t [MSHR_SIZE-1:0] addr_table;
    mshr_data_t [MSHR_SIZE-1:0] data_table;
    logic [MSHR_SIZE-1:0] valid_table, valid_n;
    logic [MSHR_SIZE-1:0] ready_table, ready_x, ready_n;
    logic [MSHR_SIZE-1:0] addr_match;
    logic [MSHR_SIZE-1:0] other_entry;
    logic                 alloc_rdy_r, alloc_rdy_n;
    logic [MSHR_ID_W-1:0] alloc_id_r, alloc_id_n;
    logic                 deq_val_r, deq_val_n, deq_val_x;
    logic [MSHR_ID_W-1:0] deq_id_r, deq_id_n, deq_id_x;
    logic                 alloc_fire;
    logic                 deq_fire;

    assign alloc_fire = alloc_valid_i && alloc_rdy_r;
    assign deq_fire   = deq_val_r && dequeue_ready_i;

    always_comb begin
        for (int i = 0; i < MSHR_SIZE; i++) begin
            addr_match[i]  = (addr_table[i] == lookup_addr_i);
            other_entry[i] = (MSHR_ID_W'(i) != lookup_id_i);
        end
    end

    // a taken entry drops out of the ready search, a fill adds its line
    always_comb begin
        ready_x = ready_table;
        if (deq_fire) begin
            ready_x[deq_id_r] = 1'b0;
        end
        if (lookup_replay_i) begin
            ready_x = ready_x | (addr_match & valid_table);
        end
    end

    // lowest ready entry
    always_comb begin
        deq_val_x = 1'b0;
        deq_id_x  = '0;
        for (int i = MSHR_SIZE - 1; i >= 0; i--) begin
            if (valid_table[i] && ready_x[i]) begin
                deq_val_x = 1'b1;
                deq_id_x  = MSHR_ID_W'(i);
            end
        end
    end

    always_comb begin
        valid_n   = valid_table;
        ready_n   = ready_x;
        deq_val_n = deq_val_r;
        deq_id_n  = deq_id_r;
        if (deq_fire) begin
            deq_val_n = deq_val_x;
            deq_id_n  = deq_id_x;
        end
        if (alloc_fire) begin
            valid_n[alloc_id_r] = 1'b1;
            ready_n[alloc_id_r] = 1'b0;
        end
        if (fill_valid_i) begin
            deq_val_n = 1'b1;
            deq_id_n  = fill_id_i;
        end
        if (release_valid_i) begin
            valid_n[release_id_i] = 1'b0;
        end
    end

    // lowest free entry for the next allocation
    always_comb begin
        alloc_rdy_n = 1'b0;
        alloc_id_n  = '0;
        for (int i = MSHR_SIZE - 1; i >= 0; i--) begin
            if (!valid_n[i]) begin
                alloc_rdy_n = 1'b1;
                alloc_id_n  = MSHR_ID_W'(i);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_table <= '0;
            ready_table <= '0;
            alloc_rdy_r <= 1'b0;
            deq_val_r   <= 1'b0;
        end else begin
            valid_table <= valid_n;
            ready_table <= ready_n;
            alloc_rdy_r <= alloc_rdy_n;
            deq_val_r   <= deq_val_n;
        end
        alloc_id_r <= alloc_id_n;
        deq_id_r   <= deq_id_n;
        if (alloc_fire) begin
            addr_table[alloc_id_r] <= alloc_addr_i;
            data_table[alloc_id_r] <= alloc_data_i;
        end
    end

    assign alloc_ready_o   = alloc_rdy_r;
    assign alloc_id_o      = alloc_id_r;
    assign fill_addr_o     = addr_table[fill_id_i];
    assign lookup_match_o  = |(other_entry & valid_table & addr_match);
    assign dequeue_valid_o = deq_val_r;
    assign dequeue_id_o    = deq_id_r;
    assign dequeue_addr_o  = addr_table[deq_id_r];
    assign dequeue_data_o  = data_table[deq_id_r];

endmodule

`default_nettype wire

//--- design/tag_store.sv
`timescale 1ns/10ps
`default_nettype none

module tag_store (
    input  wire                                  clk,
    input  wire                                  reset,
    input  wire [cache_bank_pkg::INDEX_W-1:0]    lookup_index_i,
    input  wire [cache_bank_pkg::TAG_W-1:0]      lookup_tag_i,
    output logic                                 hit_o,
    input  wire                                  fill_valid_i,
    input  wire cache_bank_pkg::line_addr_t      fill_addr_i
);
    import cache_bank_pkg::*;

    logic [NUM_LINES-1:0] valid_q;
    logic [TAG_W-1:0]     tags_q [NUM_LINES];

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= '0;
        end else if (fill_valid_i) begin
            valid_q[fill_addr_i.index] <= 1'b1;
        end
        if (fill_valid_i) begin
            tags_q[fill_addr_i.index] <= fill_addr_i.tag;
        end
        // compare lands one cycle after the address
        hit_o <= valid_q[lookup_index_i] && (tags_q[lookup_index_i] == lookup_tag_i);
    end

endmodule

`default_nettype wire

//--- design/line_store.sv
`timescale 1ns/10ps
`default_nettype none

module line_store (
    input  wire                                  clk,
    input  wire [cache_bank_pkg::INDEX_W-1:0]    index_i,
    input  wire [cache_bank_pkg::OFFSET_W-1:0]   offset_i,
    output logic [cache_bank_pkg::WORD_W-1:0]    word_o,
    input  wire                                  fill_valid_i,
    input  wire [cache_bank_pkg::INDEX_W-1:0]    fill_index_i,
    input  wire [cache_bank_pkg::LINE_W-1:0]     fill_line_i
);
    import cache_bank_pkg::*;

    logic [LINE_W-1:0]   lines_q [NUM_LINES];
    logic [LINE_W-1:0]   line_q;
    logic [OFFSET_W-1:0] offset_q;

    always_ff @(posedge clk) begin
        if (fill_valid_i) begin
            lines_q[fill_index_i] <= fill_line_i;
        end
        line_q   <= lines_q[index_i];
        offset_q <= offset_i;
    end

    // word 0 sits in the low bits
    assign word_o = line_q[offset_q * WORD_W +: WORD_W];

endmodule

`default_nettype wire

//--- design/bank_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module bank_ctrl (
    input  wire                                      clk,
    input  wire                                      reset,
    input  wire                                      core_req_valid_i,
    input  wire cache_bank_pkg::core_req_t           core_req_i,
    output logic                                     core_req_ready_o,
    output logic                                     core_rsp_valid_o,
    output cache_bank_pkg::core_rsp_t                core_rsp_o,
    output logic                                     mem_req_valid_o,
    output cache_bank_pkg::mem_req_t                 mem_req_o,
    input  wire                                      mem_req_ready_i,
    input  wire                                      mem_rsp_valid_i,
    input  wire cache_bank_pkg::mem_rsp_t            mem_rsp_i,
    output logic                                     mem_rsp_ready_o,
    output logic                                     alloc_valid_o,
    output cache_bank_pkg::line_addr_t               alloc_addr_o,
    output cache_bank_pkg::mshr_data_t               alloc_data_o,
    input  wire [cache_bank_pkg::MSHR_ID_W-1:0]      alloc_id_i,
    input  wire                                      alloc_ready_i,
    output logic                                     fill_valid_o,
    output logic [cache_bank_pkg::MSHR_ID_W-1:0]     fill_id_o,
    input  wire cache_bank_pkg::line_addr_t          fill_addr_i,
    output cache_bank_pkg::line_addr_t               lookup_addr_o,
    output logic [cache_bank_pkg::MSHR_ID_W-1:0]     lookup_id_o,
    output logic                                     lookup_replay_o,
    input  wire                                      lookup_match_i,
    input  wire                                      dequeue_valid_i,
    input  wire [cache_bank_pkg::MSHR_ID_W-1:0]      dequeue_id_i,
    input  wire cache_bank_pkg::line_addr_t          dequeue_addr_i,
    input  wire cache_bank_pkg::mshr_data_t          dequeue_data_i,
    output logic                                     dequeue_ready_o,
    output logic                                     release_valid_o,
    output logic [cache_bank_pkg::MSHR_ID_W-1:0]     release_id_o,
    input  wire                                      hit_i,
    output logic [cache_bank_pkg::INDEX_W-1:0]       tag_index_o,
    output logic [cache_bank_pkg::TAG_W-1:0]         tag_tag_o,
    output logic [cache_bank_pkg::INDEX_W-1:0]       line_index_o,
    output logic [cache_bank_pkg::OFFSET_W-1:0]      line_offset_o,
    input  wire [cache_bank_pkg::WORD_W-1:0]         word_i,
    output logic [cache_bank_pkg::INDEX_W-1:0]       line_fill_index_o,
    output logic [cache_bank_pkg::LINE_W-1:0]        line_fill_o
);
    import cache_bank_pkg::*;

    bank_state_e          state_q, state_n;
    core_req_t            req_q;
    mem_rsp_t             fill_q;
    mem_req_t             mem_req_q;
    logic [MSHR_ID_W-1:0] rep_id_q;
    mshr_data_t           rep_data_q;
    logic                 rsp_valid_q;
    core_rsp_t            rsp_q;
    logic                 run_q;
    logic                 core_fire;
    logic                 rsp_fire;
    logic                 deq_fire;

    // replay drains before fills, fills before new requests
    assign dequeue_ready_o  = (state_q == IDLE);
    // memory responses open one cycle after reset
    assign mem_rsp_ready_o  = (state_q == IDLE) && !dequeue_valid_i && run_q;
    assign core_req_ready_o = (state_q == IDLE) && alloc_ready_i && !dequeue_valid_i
                              && !mem_rsp_valid_i;

    assign deq_fire  = dequeue_valid_i && dequeue_ready_o;
    assign rsp_fire  = mem_rsp_valid_i && mem_rsp_ready_o;
    assign core_fire = core_req_valid_i && core_req_ready_o;

    always_comb begin
        state_n = state_q;
        case (state_q)
            IDLE: begin
                if (deq_fire) begin
                    state_n = REPLAY;
                end else if (rsp_fire) begin
                    state_n = FILL;
                end else if (core_fire) begin
                    state_n = TAG_CHECK;
                end
            end
            TAG_CHECK: begin
                // join an in-flight miss on the same line
                state_n = (!hit_i && !lookup_match_i) ? MEM_ISSUE : IDLE;
            end
            MEM_ISSUE: begin
                if (mem_req_ready_i) begin
                    state_n = IDLE;
                end
            end
            default: state_n = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q     <= IDLE;
            rsp_valid_q <= 1'b0;
            run_q       <= 1'b0;
        end else begin
            state_q     <= state_n;
            rsp_valid_q <= ((state_q == TAG_CHECK) && hit_i) || (state_q == REPLAY);
            run_q       <= 1'b1;
        end
        if (core_fire) begin
            req_q <= core_req_i;
        end
        if (rsp_fire) begin
            fill_q <= mem_rsp_i;
        end
        if (deq_fire) begin
            rep_id_q   <= dequeue_id_i;
            rep_data_q <= dequeue_data_i;
        end
        if (state_q == TAG_CHECK) begin
            mem_req_q.id   <= alloc_id_i;
            mem_req_q.addr <= req_q.addr.line;
        end
        rsp_q.core_tag <= (state_q == REPLAY) ? rep_data_q.core_tag : req_q.core_tag;
        rsp_q.data     <= word_i;
    end

    assign core_rsp_valid_o = rsp_valid_q;
    assign core_rsp_o       = rsp_q;
    assign mem_req_valid_o  = (state_q == MEM_ISSUE);
    assign mem_req_o        = mem_req_q;

    assign alloc_valid_o         = (state_q == TAG_CHECK) && !hit_i;
    assign alloc_addr_o          = req_q.addr.line;
    assign alloc_data_o.core_tag = req_q.core_tag;
    assign alloc_data_o.offset   = req_q.addr.offset;

    assign fill_valid_o    = (state_q == FILL);
    assign fill_id_o       = fill_q.id;
    assign lookup_replay_o = (state_q == FILL);
    assign lookup_addr_o   = (state_q == FILL) ? fill_addr_i : req_q.addr.line;
    assign lookup_id_o     = (state_q == FILL) ? fill_q.id : alloc_id_i;
    assign release_valid_o = (state_q == REPLAY);
    assign release_id_o    = rep_id_q;

    // stores are read straight from the incoming request or dequeue
    assign tag_index_o       = core_req_i.addr.line.index;
    assign tag_tag_o         = core_req_i.addr.line.tag;
    assign line_index_o      = dequeue_valid_i ? dequeue_addr_i.index
                                               : core_req_i.addr.line.index;
    assign line_offset_o     = dequeue_valid_i ? dequeue_data_i.offset : core_req_i.addr.offset;
    assign line_fill_index_o = fill_addr_i.index;
    assign line_fill_o       = fill_q.line;

endmodule

`default_nettype wire

//--- design/cache_bank.sv
`timescale 1ns/10ps
`default_nettype none

module cache_bank (
    input  wire                              clk,
    input  wire                              reset,
    input  wire                              core_req_valid_i,
    input  wire cache_bank_pkg::core_req_t   core_req_i,
    output logic                             core_req_ready_o,
    output logic                             core_rsp_valid_o,
    output cache_bank_pkg::core_rsp_t        core_rsp_o,
    output logic                             mem_req_valid_o,
    output cache_bank_pkg::mem_req_t         mem_req_o,
    input  wire                              mem_req_ready_i,
    input  wire                              mem_rsp_valid_i,
    input  wire cache_bank_pkg::mem_rsp_t    mem_rsp_i,
    output logic                             mem_rsp_ready_o
);
    import cache_bank_pkg::*;

    logic                 alloc_valid, alloc_ready;
    line_addr_t           alloc_addr;
    mshr_data_t           alloc_data;
    logic [MSHR_ID_W-1:0] alloc_id;
    logic                 fill_valid;
    logic [MSHR_ID_W-1:0] fill_id;
    line_addr_t           fill_addr;
    line_addr_t           lookup_addr;
    logic [MSHR_ID_W-1:0] lookup_id;
    logic                 lookup_replay, lookup_match;
    logic                 deq_valid, deq_ready;
    logic [MSHR_ID_W-1:0] deq_id;
    line_addr_t           deq_addr;
    mshr_data_t           deq_data;
    logic                 release_valid;
    logic [MSHR_ID_W-1:0] release_id;
    logic                 hit;
    logic [INDEX_W-1:0]   tag_index, line_index, line_fill_index;
    logic [TAG_W-1:0]     tag_tag;
    logic [OFFSET_W-1:0]  line_offset;
    logic [WORD_W-1:0]    word;
    logic [LINE_W-1:0]    line_fill;

    bank_ctrl ctrl_i (
        .clk, .reset,
        .core_req_valid_i, .core_req_i, .core_req_ready_o, .core_rsp_valid_o, .core_rsp_o,
        .mem_req_valid_o, .mem_req_o, .mem_req_ready_i,
        .mem_rsp_valid_i, .mem_rsp_i, .mem_rsp_ready_o,
        .alloc_valid_o (alloc_valid), .alloc_addr_o (alloc_addr), .alloc_data_o (alloc_data),
        .alloc_id_i (alloc_id), .alloc_ready_i (alloc_ready),
        .fill_valid_o (fill_valid), .fill_id_o (fill_id), .fill_addr_i (fill_addr),
        .lookup_addr_o (lookup_addr), .lookup_id_o (lookup_id),
        .lookup_replay_o (lookup_replay), .lookup_match_i (lookup_match),
        .dequeue_valid_i (deq_valid), .dequeue_id_i (deq_id), .dequeue_addr_i (deq_addr),
        .dequeue_data_i (deq_data), .dequeue_ready_o (deq_ready),
        .release_valid_o (release_valid), .release_id_o (release_id),
        .hit_i (hit), .tag_index_o (tag_index), .tag_tag_o (tag_tag),
        .line_index_o (line_index), .line_offset_o (line_offset), .word_i (word),
        .line_fill_index_o (line_fill_index), .line_fill_o (line_fill)
    );

    miss_resrv mshr_i (
        .clk, .reset,
        .alloc_valid_i (alloc_valid), .alloc_addr_i (alloc_addr), .alloc_data_i (alloc_data),
        .alloc_id_o (alloc_id), .alloc_ready_o (alloc_ready),
        .fill_valid_i (fill_valid), .fill_id_i (fill_id), .fill_addr_o (fill_addr),
        .lookup_addr_i (lookup_addr), .lookup_id_i (lookup_id),
        .lookup_replay_i (lookup_replay), .lookup_match_o (lookup_match),
        .dequeue_valid_o (deq_valid), .dequeue_id_o (deq_id), .dequeue_addr_o (deq_addr),
        .dequeue_data_o (deq_data), .dequeue_ready_i (deq_ready),
        .release_valid_i (release_valid), .release_id_i (release_id)
    );

    tag_store tags_i (
        .clk, .reset,
        .lookup_index_i (tag_index), .lookup_tag_i (tag_tag), .hit_o (hit),
        .fill_valid_i (fill_valid), .fill_addr_i (fill_addr)
    );

    line_store lines_i (
        .clk,
        .index_i (line_index), .offset_i (line_offset), .word_o (word),
        .fill_valid_i (fill_valid), .fill_index_i (line_fill_index), .fill_line_i (line_fill)
    );

endmodule

`default_nettype wire

//--- bench/bank_checker.sv
`timescale 1ns/10ps
`default_nettype none

module bank_checker (
    input  wire                             clk,
    input  wire                             reset,
    input  wire                             core_req_valid_i,
    input  wire cache_bank_pkg::core_req_t  core_req_i,
    input  wire                             core_req_ready_i,
    input  wire                             core_rsp_valid_i,
    input  wire cache_bank_pkg::core_rsp_t  core_rsp_i,
    input  wire                             mem_req_valid_i,
    input  wire cache_bank_pkg::mem_req_t   mem_req_i,
    input  wire                             mem_req_ready_i,
    input  wire                             mem_rsp_valid_i,
    input  wire cache_bank_pkg::mem_rsp_t   mem_rsp_i,
    input  wire                             mem_rsp_ready_i,
    output int                              error_count_o
);
    import cache_bank_pkg::*;

    localparam int NUM_TAGS = 1 << CORE_TAG_W;

    int                            errors = 0;
    int                            cycle = 0;
    int                            reset_cycles = 0;
    bit                            first_after;
    bit [NUM_TAGS-1:0]             busy;
    bit [NUM_TAGS-1:0]             tag_hit;
    word_addr_t                    tag_addr [NUM_TAGS];
    int                            tag_due [NUM_TAGS];
    bit [NUM_LINES-1:0]            res_valid;
    line_addr_t                    res_line [NUM_LINES];
    bit [(1 << LINE_ADDR_W)-1:0]   pending;
    line_addr_t                    id_line [MSHR_SIZE];
    int                            miss_count;
    bit                            chk_armed;
    bit                            chk_expect;
    int                            chk_cycle;
    line_addr_t                    chk_line;
    bit                            hold_prev;
    mem_req_t                      req_prev;

    assign error_count_o = errors;

    // memory contents, same rule the responder uses
    function automatic logic [WORD_W-1:0] line_word(input line_addr_t a,
                                                   input logic [OFFSET_W-1:0] off);
        return {a, 6'h2b, off, ~a, a ^ {off, off, off, off}};
    endfunction

    task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("[FAIL] %s expected %0h actual %0h", name, exp, act);
            errors++;
        end
    endtask

    task automatic report_problem(input string msg);
        $display("error at cycle %0d: %s", cycle, msg);
        errors++;
    endtask

    task automatic check_quiet(input string when);
        if (core_rsp_valid_i !== 1'b0 || mem_req_valid_i !== 1'b0 || mem_rsp_ready_i !== 1'b0) begin
            report_problem({"handshake outputs not low ", when});
        end
    endtask

    always @(posedge clk) begin : watch
        logic [CORE_TAG_W-1:0] t;
        word_addr_t            a;
        line_addr_t            l;
        cycle++;
        if (reset) begin
            // state is unknown until the first reset edge
            if (reset_cycles > 0) begin
                check_quiet("during reset");
            end
            reset_cycles++;
            first_after = 1'b1;
            busy        = '0;
            res_valid   = '0;
            pending     = '0;
            miss_count  = 0;
            chk_armed   = 1'b0;
            hold_prev   = 1'b0;
        end else begin
            if (first_after) begin
                check_quiet("on the first cycle after reset");
            end
            first_after = 1'b0;
            if (core_rsp_valid_i) begin
                t = core_rsp_i.core_tag;
                if (!busy[t]) begin
                    report_problem($sformatf("response with unknown tag %0d", t));
                end else begin
                    a = tag_addr[t];
                    compare($sformatf("rsp_data tag %0d", t), line_word(a.line, a.offset),
                            core_rsp_i.data);
                    if (tag_hit[t]) begin
                        compare($sformatf("hit_latency tag %0d", t), tag_due[t], cycle);
                    end else begin
                        miss_count--;
                    end
                    busy[t] = 1'b0;
                end
            end
            if (mem_rsp_valid_i && mem_rsp_ready_i) begin
                l = id_line[mem_rsp_i.id];
                pending[l] = 1'b0;
                res_valid[l.index] = 1'b1;
                res_line[l.index]  = l;
            end
            if (hold_prev) begin
                if (!mem_req_valid_i) begin
                    report_problem("memory request dropped before it was accepted");
                end else begin
                    compare("mem_req_hold", req_prev, mem_req_i);
                end
            end
            hold_prev = mem_req_valid_i && !mem_req_ready_i;
            req_prev  = mem_req_i;
            if (mem_req_valid_i && mem_req_ready_i) begin
                if (!pending[mem_req_i.addr]) begin
                    report_problem("memory request for a line with no open miss");
                end
                id_line[mem_req_i.id] = mem_req_i.addr;
            end
            // miss path puts the request out two cycles after acceptance
            if (chk_armed && cycle == chk_cycle) begin
                chk_armed = 1'b0;
                if (chk_expect && !mem_req_valid_i) begin
                    report_problem("missing memory request for a new miss");
                end else if (chk_expect) begin
                    compare("mem_req_line", chk_line, mem_req_i.addr);
                end else if (mem_req_valid_i) begin
                    report_problem("memory request for a resident or already requested line");
                end
            end
            if (miss_count >= MSHR_SIZE && core_req_ready_i) begin
                report_problem("core request ready while all miss entries are in use");
            end
            if (core_req_valid_i && core_req_ready_i) begin
                t = core_req_i.core_tag;
                a = core_req_i.addr;
                busy[t]     = 1'b1;
                tag_addr[t] = a;
                tag_hit[t]  = res_valid[a.line.index] && (res_line[a.line.index] == a.line);
                tag_due[t]  = cycle + 2;
                chk_armed   = 1'b1;
                chk_cycle   = cycle + 2;
                chk_line    = a.line;
                chk_expect  = !tag_hit[t] && !pending[a.line];
                if (!tag_hit[t]) begin
                    miss_count++;
                    if (chk_expect) begin
                        pending[a.line] = 1'b1;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- bench/cache_bank_tb.sv
`timescale 1ns/10ps
`default_nettype none

module cache_bank_tb;
    import cache_bank_pkg::*;

    localparam int NUM_REQS   = 600;
    localparam int WAIT_LIMIT = 2000;
    localparam int NUM_TAGS   = 1 << CORE_TAG_W;

    logic                  clk = 1'b0;
    logic                  reset = 1'b1;
    logic                  core_req_valid_i = 1'b0;
    core_req_t             core_req_i = '0;
    logic                  core_req_ready_o;
    logic                  core_rsp_valid_o;
    core_rsp_t             core_rsp_o;
    logic                  mem_req_valid_o;
    mem_req_t              mem_req_o;
    logic                  mem_req_ready_i = 1'b0;
    logic                  mem_rsp_valid_i = 1'b0;
    mem_rsp_t              mem_rsp_i = '0;
    logic                  mem_rsp_ready_o;
    int                    error_count;

    logic [31:0]           lfsr = 32'h95dd80ad;
    logic [CORE_TAG_W-1:0] free_tags [$];
    logic [NUM_TAGS-1:0]   tag_busy = '0;
    mem_req_t              pend_q [$];
    int                    req_hold;
    int                    rsp_hold;
    int                    delay_cnt;
    int                    rsp_sel;
    bit                    rsp_active;
    mem_rsp_t              rsp_next = '0;
    int                    timeouts = 0;

    always #10 clk = ~clk;

    cache_bank cache_bank_i (
        .clk, .reset,
        .core_req_valid_i, .core_req_i, .core_req_ready_o, .core_rsp_valid_o, .core_rsp_o,
        .mem_req_valid_o, .mem_req_o, .mem_req_ready_i,
        .mem_rsp_valid_i, .mem_rsp_i, .mem_rsp_ready_o
    );

    bank_checker check_i (
        .clk, .reset,
        .core_req_valid_i (core_req_valid_i), .core_req_i (core_req_i),
        .core_req_ready_i (core_req_ready_o),
        .core_rsp_valid_i (core_rsp_valid_o), .core_rsp_i (core_rsp_o),
        .mem_req_valid_i (mem_req_valid_o), .mem_req_i (mem_req_o),
        .mem_req_ready_i (mem_req_ready_i),
        .mem_rsp_valid_i (mem_rsp_valid_i), .mem_rsp_i (mem_rsp_i),
        .mem_rsp_ready_i (mem_rsp_ready_o), .error_count_o (error_count)
    );

    // galois lfsr, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
        end
        return v;
    endfunction

    function automatic logic [WORD_W-1:0] line_word(input line_addr_t a,
                                                   input logic [OFFSET_W-1:0] off);
        return {a, 6'h2b, off, ~a, a ^ {off, off, off, off}};
    endfunction

    function automatic logic [LINE_W-1:0] build_line(input line_addr_t a);
        logic [LINE_W-1:0] l;
        for (int i = 0; i < WORDS_PER_LINE; i++) begin
            l[i*WORD_W +: WORD_W] = line_word(a, OFFSET_W'(i));
        end
        return l;
    endfunction

    task automatic send_request();
        int          waited;
        bit          accepted;
        logic [31:0] r;
        core_req_t   req;
        waited = 0;
        while (free_tags.size() == 0 && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (free_tags.size() == 0) begin
            $display("timeout: no core tag came back within %0d cycles", WAIT_LIMIT);
            timeouts++;
            return;
        end
        r = rand_bits(9);
        req.core_tag = free_tags.pop_front();
        // 32 lines folded onto 8 indices
        req.addr.line.index = {1'b0, r[2:0]};
        req.addr.line.tag   = {r[4:3], 2'b01};
        req.addr.offset     = r[6:5];
        tag_busy[req.core_tag] = 1'b1;
        core_req_i       = req;
        core_req_valid_i = 1'b1;
        waited   = 0;
        accepted = 1'b0;
        while (!accepted && waited < WAIT_LIMIT) begin
            @(posedge clk);
            accepted = core_req_ready_o;
            waited++;
        end
        @(negedge clk);
        core_req_valid_i = 1'b0;
        if (!accepted) begin
            $display("timeout: core request not accepted within %0d cycles", WAIT_LIMIT);
            timeouts++;
        end else begin
            repeat (r[8:7]) @(negedge clk);
        end
    endtask

    task automatic wait_for_drain();
        int waited;
        waited = 0;
        while (timeouts == 0 && free_tags.size() != NUM_TAGS && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (timeouts == 0 && free_tags.size() != NUM_TAGS) begin
            $display("timeout: %0d tags never got a response", NUM_TAGS - free_tags.size());
            timeouts++;
        end
    endtask

    always @(posedge clk) begin
        if (!reset && core_rsp_valid_o && tag_busy[core_rsp_o.core_tag]) begin
            tag_busy[core_rsp_o.core_tag] = 1'b0;
            free_tags.push_back(core_rsp_o.core_tag);
        end
    end

    // memory model, decisions made here and driven on the falling edge
    always @(posedge clk) begin : responder
        mem_req_t pick;
        if (reset) begin
            pend_q.delete();
            req_hold   = 0;
            rsp_hold   = 0;
            delay_cnt  = 0;
            rsp_active = 1'b0;
        end else begin
            if (mem_req_valid_o && mem_req_ready_i) begin
                pend_q.push_back(mem_req_o);
            end
            if (mem_rsp_valid_i && mem_rsp_ready_o) begin
                pend_q.delete(rsp_sel);
                rsp_active = 1'b0;
            end
            if (req_hold > 0) begin
                req_hold--;
            end else if (rand_bits(3) == 0) begin
                req_hold = int'(rand_bits(4));
            end
            // long response stalls let the miss table run full
            if (rsp_hold > 0) begin
                rsp_hold--;
            end else if (rand_bits(4) == 0) begin
                rsp_hold = int'(rand_bits(6));
            end
            if (!rsp_active && rsp_hold == 0 && pend_q.size() > 0) begin
                if (delay_cnt > 0) begin
                    delay_cnt--;
                end else begin
                    rsp_sel       = int'(rand_bits(8)) % pend_q.size();
                    pick          = pend_q[rsp_sel];
                    rsp_next.id   = pick.id;
                    rsp_next.line = build_line(pick.addr);
                    rsp_active    = 1'b1;
                    delay_cnt     = int'(rand_bits(3));
                end
            end
        end
    end

    always @(negedge clk) begin
        mem_req_ready_i = !reset && (req_hold == 0);
        mem_rsp_valid_i = rsp_active;
        mem_rsp_i       = rsp_next;
    end

    initial begin
        for (int i = 0; i < NUM_TAGS; i++) begin
            free_tags.push_back(CORE_TAG_W'(i));
        end
        repeat (10) @(negedge clk);
        reset = 1'b0;
        for (int n = 0; n < NUM_REQS && timeouts == 0; n++) begin
            send_request();
        end
        wait_for_drain();
        $display("errors: %0d check, %0d timeout", error_count, timeouts);
        if (error_count == 0 && timeouts == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
design/cache_bank_pkg.sv
design/miss_resrv.sv
design/tag_store.sv
design/line_store.sv
design/bank_ctrl.sv
design/cache_bank.sv
bench/bank_checker.sv
bench/cache_bank_tb.sv
